//--- list.f
source/lms_pkg.sv
source/rx_iq_deinterleave.sv
source/iq_pair_fifo.sv
source/tx_iq_interleave.sv
source/lms_frontend.sv
sim/tb_lms_frontend.sv

//--- Bender.yml
package:
  name: lms_frontend

sources:
  # Design, in compile order
  - files:
      - source/lms_pkg.sv
      - source/rx_iq_deinterleave.sv
      - source/iq_pair_fifo.sv
      - source/tx_iq_interleave.sv
      - source/lms_frontend.sv

  # Testbench, top module tb_lms_frontend
  - target: simulation
    files:
      - sim/tb_lms_frontend.sv

//--- sim/tb_lms_frontend.sv
`timescale 1ns/10ps

module tb_lms_frontend;

   import lms_pkg::*;

   localparam int DEPTH      = FIFO_DEPTH_DEF;
   localparam int CLK_PERIOD = 10;
   localparam int RST_CYC    = 10;
   localparam int IDLE_CYC   = 24;
   localparam int ALT_CYC    = 200;
   localparam int RAND_CYC   = 300;
   localparam int BURST_CYC  = 4 * DEPTH;
   localparam int DRAIN_CYC  = 4 * DEPTH;
   localparam int MIX_CYC    = 400;
   // Five resets plus every test body with a little slack per test
   localparam int TOTAL_CYC  = 5 * (RST_CYC + 2) + IDLE_CYC + ALT_CYC + RAND_CYC
                               + BURST_CYC + DRAIN_CYC + MIX_CYC + 20;

   logic                  dsp_clk;
   logic                  rst_i;
   logic [NUM_CH-1:0]     rx_iqsel;
   sample_t               rx_d [NUM_CH];
   logic [NUM_CH-1:0]     tx_iqsel;
   sample_t               tx_d [NUM_CH];
   logic [NUM_CH-1:0]     overflow;

   integer seed;
   logic   check_en;

   // One set of model state per channel
   logic      m_pv    [NUM_CH];  // Pair strobe register
   sample_t   m_pi    [NUM_CH];
   sample_t   m_pq    [NUM_CH];
   sample_t   mq_i    [NUM_CH][DEPTH];  // Pair queue with the front at index 0
   sample_t   mq_q    [NUM_CH][DEPTH];
   int        m_cnt   [NUM_CH];
   iq_phase_e m_phase [NUM_CH];
   sample_t   m_qhold [NUM_CH];
   sample_t   exp_d   [NUM_CH];
   logic      exp_sel [NUM_CH];
   logic      exp_ovf [NUM_CH];

   lms_frontend
   #(
      .FIFO_DEPTH (DEPTH)
   )
   u_lms_frontend
   (
      .dsp_clk    (dsp_clk),
      .rst_i      (rst_i),
      .rx_iqsel_i (rx_iqsel),
      .rx_d_i     (rx_d),
      .tx_iqsel_o (tx_iqsel),
      .tx_d_o     (tx_d),
      .overflow_o (overflow)
   );

   initial
   begin
      dsp_clk = 1'b0;
      forever
         #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   initial
   begin
      #(TOTAL_CYC * CLK_PERIOD + 500);
      $display("Timeout, the tests did not finish in %0d cycles", TOTAL_CYC);
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
   end

   function automatic sample_t rand_sample();
      return sample_t'($random(seed));
   endfunction

   task automatic check_sample(input string name, input sample_t exp, input sample_t act);
      if (act !== exp)
      begin
         $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, act);
         $display("TEST FAILED");
         $fatal(1, "stopping at first error");
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
         $display("TEST FAILED");
         $fatal(1, "stopping at first error");
      end
   endtask

   // Mirrors one edge of every channel from pre-edge values
   always @(posedge dsp_clk)
   begin : cycle_model
      logic full;
      logic empty;
      logic pop;
      logic push;
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         if (rst_i)
         begin
            m_pv[ch]    = 1'b0;
            m_pi[ch]    = '0;
            m_cnt[ch]   = 0;
            m_phase[ch] = IQ_PHASE_I;
            exp_d[ch]   = '0;
            exp_sel[ch] = 1'b0;
            exp_ovf[ch] = 1'b0;
         end
         else
         begin
            full  = (m_cnt[ch] == DEPTH);
            empty = (m_cnt[ch] == 0);
            pop   = (m_phase[ch] == IQ_PHASE_I) && !empty;
            push  = m_pv[ch] && !full;
            exp_sel[ch] = (m_phase[ch] == IQ_PHASE_Q);
            if (m_phase[ch] == IQ_PHASE_I)
            begin
               exp_d[ch]   = empty ? sample_t'(0) : mq_i[ch][0];  // Zero pair on underrun
               m_qhold[ch] = empty ? sample_t'(0) : mq_q[ch][0];
            end
            else
               exp_d[ch] = m_qhold[ch];
            if (m_pv[ch] && full)
               exp_ovf[ch] = 1'b1;  // Pair lost and the flag stays high
            if (pop)
            begin
               for (int k = 0; k < DEPTH - 1; k++)
               begin
                  mq_i[ch][k] = mq_i[ch][k+1];
                  mq_q[ch][k] = mq_q[ch][k+1];
               end
               m_cnt[ch]--;
            end
            if (push)
            begin
               mq_i[ch][m_cnt[ch]] = m_pi[ch];
               mq_q[ch][m_cnt[ch]] = m_pq[ch];
               m_cnt[ch]++;
            end
            if (rx_iqsel[ch])
               m_pq[ch] = rx_d[ch];
            else
               m_pi[ch] = rx_d[ch];
            m_pv[ch]    = rx_iqsel[ch];
            m_phase[ch] = (m_phase[ch] == IQ_PHASE_I) ? IQ_PHASE_Q : IQ_PHASE_I;
         end
      end
   end

   // Outputs are settled half a cycle after the edge
   always @(negedge dsp_clk)
   begin
      if (check_en)
      begin
         for (int ch = 0; ch < NUM_CH; ch++)
         begin
            check_sample($sformatf("tx_d_o[%0d]", ch), exp_d[ch], tx_d[ch]);
            check_bit($sformatf("tx_iqsel_o[%0d]", ch), exp_sel[ch], tx_iqsel[ch]);
            check_bit($sformatf("overflow_o[%0d]", ch), exp_ovf[ch], overflow[ch]);
         end
      end
   end

   task automatic apply_reset();
      @(posedge dsp_clk);
      rst_i    <= 1'b1;
      rx_iqsel <= '0;
      for (int ch = 0; ch < NUM_CH; ch++)
         rx_d[ch] <= '0;
      repeat (RST_CYC) @(posedge dsp_clk);
      rst_i <= 1'b0;
   endtask

   // Only I words, so TX must send zero pairs
   task automatic idle_no_q();
      repeat (IDLE_CYC)
      begin
         @(posedge dsp_clk);
         for (int ch = 0; ch < NUM_CH; ch++)
         begin
            rx_iqsel[ch] <= 1'b0;
            rx_d[ch]     <= rand_sample();
         end
      end
   endtask

   task automatic alternate_pairs();
      for (int n = 0; n < ALT_CYC; n++)
      begin
         @(posedge dsp_clk);
         for (int ch = 0; ch < NUM_CH; ch++)
         begin
            rx_iqsel[ch] <= n[0];  // I first then Q
            rx_d[ch]     <= rand_sample();
         end
      end
   endtask

   task automatic random_select();
      repeat (RAND_CYC)
      begin
         @(posedge dsp_clk);
         for (int ch = 0; ch < NUM_CH; ch++)
         begin
            rx_iqsel[ch] <= $random(seed) & 1;
            rx_d[ch]     <= rand_sample();
         end
      end
   endtask

   // Q every cycle fills the FIFO twice as fast as TX drains it
   task automatic overflow_burst();
      repeat (BURST_CYC)
      begin
         @(posedge dsp_clk);
         for (int ch = 0; ch < NUM_CH; ch++)
         begin
            rx_iqsel[ch] <= 1'b1;
            rx_d[ch]     <= rand_sample();
         end
      end
      @(negedge dsp_clk);
      // The burst is longer than the FIFO so the DUT flag must be up by now
      for (int ch = 0; ch < NUM_CH; ch++)
         check_bit($sformatf("overflow_o[%0d]", ch), 1'b1, overflow[ch]);
      // Dropped pairs must not show up in the drain
      repeat (DRAIN_CYC)
      begin
         @(posedge dsp_clk);
         for (int ch = 0; ch < NUM_CH; ch++)
         begin
            rx_iqsel[ch] <= 1'b0;
            rx_d[ch]     <= rand_sample();
         end
      end
   endtask

   // Channel 0 alternates while channel 1 gets random select
   task automatic independent_channels();
      for (int n = 0; n < MIX_CYC; n++)
      begin
         @(posedge dsp_clk);
         rx_iqsel[0] <= n[0];
         rx_d[0]     <= rand_sample();
         rx_iqsel[1] <= $random(seed) & 1;
         rx_d[1]     <= rand_sample();
      end
   endtask

   initial
   begin
      seed     = 80631;
      check_en = 1'b0;
      rst_i    = 1'b1;
      rx_iqsel = '0;
      for (int ch = 0; ch < NUM_CH; ch++)
         rx_d[ch] = '0;
      apply_reset();
      check_en = 1'b1;
      idle_no_q();
      apply_reset();
      alternate_pairs();
      apply_reset();
      random_select();
      apply_reset();
      overflow_burst();
      apply_reset();
      independent_channels();
      repeat (4) @(posedge dsp_clk);
      @(negedge dsp_clk);
      $display("TEST OK");
      $finish;
   end

endmodule

//--- source/lms_frontend.sv
`timescale 1ns/10ps

module lms_frontend
#(
   parameter int FIFO_DEPTH = lms_pkg::FIFO_DEPTH_DEF
)
(
   input  logic                          dsp_clk,
   input  logic                          rst_i,
   // Receive buses from the LMS ADCs
   input  logic [lms_pkg::NUM_CH-1:0]    rx_iqsel_i,
   input  lms_pkg::sample_t              rx_d_i [lms_pkg::NUM_CH],
   // Transmit buses to the LMS DACs
   output logic [lms_pkg::NUM_CH-1:0]    tx_iqsel_o,
   output lms_pkg::sample_t              tx_d_o [lms_pkg::NUM_CH],
   output logic [lms_pkg::NUM_CH-1:0]    overflow_o
);

   import lms_pkg::*;

   // Each channel is an independent loopback, nothing is shared
   for (genvar ch = 0; ch < NUM_CH; ch++)
   begin : g_ch
      logic    pair_valid;
      sample_t pair_i;
      sample_t pair_q;
      sample_t front_i;
      sample_t front_q;
      logic    empty;
      logic    pop;

      rx_iq_deinterleave u_rx_iq_deinterleave
      (
         .dsp_clk      (dsp_clk),
         .rst_i        (rst_i),
         .rx_iqsel_i   (rx_iqsel_i[ch]),
         .rx_d_i       (rx_d_i[ch]),
         .pair_valid_o (pair_valid),
         .pair_i_o     (pair_i),
         .pair_q_o     (pair_q)
      );

      // Absorbs the gap between RX pair rate and the fixed TX slot rate
      iq_pair_fifo
      #(
         .FIFO_DEPTH (FIFO_DEPTH)
      )
      u_iq_pair_fifo
      (
         .dsp_clk      (dsp_clk),
         .rst_i        (rst_i),
         .pair_valid_i (pair_valid),
         .pair_i_i     (pair_i),
         .pair_q_i     (pair_q),
         .pop_i        (pop),
         .front_i_o    (front_i),
         .front_q_o    (front_q),
         .empty_o      (empty),
         .overflow_o   (overflow_o[ch])
      );

      tx_iq_interleave u_tx_iq_interleave
      (
         .dsp_clk    (dsp_clk),
         .rst_i      (rst_i),
         .front_i_i  (front_i),
         .front_q_i  (front_q),
         .empty_i    (empty),
         .pop_o      (pop),
         .tx_iqsel_o (tx_iqsel_o[ch]),
         .tx_d_o     (tx_d_o[ch])
      );
   end

endmodule

//--- source/tx_iq_interleave.sv
`timescale 1ns/10ps

module tx_iq_interleave
(
   input  logic             dsp_clk,
   input  logic             rst_i,
   input  lms_pkg::sample_t front_i_i,
   input  lms_pkg::sample_t front_q_i,
   input  logic             empty_i,
   output logic             pop_o,
   output logic             tx_iqsel_o,
   output lms_pkg::sample_t tx_d_o
);

   import lms_pkg::*;

   iq_phase_e phase;   // Half of the pair sent at the next edge
   sample_t   q_hold;  // Q of the pair whose I is on the bus

   // Free-running half rate toggle starting on I
   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
         phase <= IQ_PHASE_I;
      else
         phase <= (phase == IQ_PHASE_I) ? IQ_PHASE_Q : IQ_PHASE_I;
   end

   // Take a pair only at the start of a pair slot
   assign pop_o = (phase == IQ_PHASE_I) && !empty_i;

   always_ff @(posedge dsp_clk)
   begin
      if (phase == IQ_PHASE_I)
      begin
         if (empty_i)
            q_hold <= '0;  // Underrun sends a zero pair
         else
            q_hold <= front_q_i;
      end
   end

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         tx_iqsel_o <= 1'b0;
         tx_d_o     <= '0;
      end
      else
      begin
         tx_iqsel_o <= (phase == IQ_PHASE_Q);  // Select travels with the data
         case (phase)
            IQ_PHASE_I:
            begin
               if (empty_i)
                  tx_d_o <= '0;
               else
                  tx_d_o <= front_i_i;
            end
            default:
            begin
               tx_d_o <= q_hold;
            end
         endcase
      end
   end

   // A popped pair leaves with select low and its Q follows with select high
   a_pop_in_i_phase: assert property (
      @(posedge dsp_clk) disable iff (rst_i)
      pop_o |=> !tx_iqsel_o ##1 tx_iqsel_o
   );

endmodule

//--- source/iq_pair_fifo.sv
`timescale 1ns/10ps

module iq_pair_fifo
#(
   parameter int FIFO_DEPTH = lms_pkg::FIFO_DEPTH_DEF
)
(
   input  logic             dsp_clk,
   input  logic             rst_i,
   input  logic             pair_valid_i,
   input  lms_pkg::sample_t pair_i_i,
   input  lms_pkg::sample_t pair_q_i,
   input  logic             pop_i,
   output lms_pkg::sample_t front_i_o,
   output lms_pkg::sample_t front_q_o,
   output logic             empty_o,
   output logic             overflow_o
);

   import lms_pkg::*;

   localparam int ADDR_W = $clog2(FIFO_DEPTH);
   localparam logic [ADDR_W:0] FULL_CNT = (ADDR_W+1)'(FIFO_DEPTH);

   sample_t mem_i [FIFO_DEPTH];
   sample_t mem_q [FIFO_DEPTH];

   logic [ADDR_W-1:0] wr_ptr;
   logic [ADDR_W-1:0] rd_ptr;
   logic [ADDR_W:0]   count;  // One extra bit to tell full from empty
   logic              full;
   logic              do_push;
   logic              do_pop;

   assign full    = (count == FULL_CNT);
   assign empty_o = (count == '0);

   // A full FIFO drops the pair even when a pop lands on the same edge
   assign do_push = pair_valid_i && !full;
   assign do_pop  = pop_i && !empty_o;

   // Read-ahead, front pair is visible while not empty
   assign front_i_o = mem_i[rd_ptr];
   assign front_q_o = mem_q[rd_ptr];

   always_ff @(posedge dsp_clk)
   begin
      if (do_push)
      begin
         mem_i[wr_ptr] <= pair_i_i;
         mem_q[wr_ptr] <= pair_q_i;
      end
   end

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, wraps by itself
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Idle, or push and pop together
         endcase
      end
   end

   // Sticky until reset
   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
         overflow_o <= 1'b0;
      else if (pair_valid_i && full)
         overflow_o <= 1'b1;
   end

   // The interleaver must look at empty_o before it pops
   a_no_pop_when_empty: assert property (
      @(posedge dsp_clk) disable iff (rst_i)
      pop_i |-> !empty_o
   );

   a_count_in_range: assert property (
      @(posedge dsp_clk) disable iff (rst_i)
      count <= FULL_CNT
   );

endmodule

//--- source/rx_iq_deinterleave.sv
`timescale 1ns/10ps

module rx_iq_deinterleave
(
   input  logic             dsp_clk,
   input  logic             rst_i,
   input  logic             rx_iqsel_i,
   input  lms_pkg::sample_t rx_d_i,
   output logic             pair_valid_o,
   output lms_pkg::sample_t pair_i_o,
   output lms_pkg::sample_t pair_q_o
);

   import lms_pkg::*;

   iq_phase_e cap_phase;  // Which half the bus carries this cycle

   assign cap_phase = rx_iqsel_i ? IQ_PHASE_Q : IQ_PHASE_I;

   // I is kept until the next I word arrives, so repeated Q words
   // all pair with the most recent I. Reset value 0 covers a Q
   // that shows up before any I.
   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         pair_i_o <= '0;
      end
      else if (cap_phase == IQ_PHASE_I)
      begin
         pair_i_o <= rx_d_i;
      end
   end

   // Q word completes a pair
   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         pair_valid_o <= 1'b0;
      end
      else
      begin
         case (cap_phase)
            IQ_PHASE_Q: pair_valid_o <= 1'b1;
            default:    pair_valid_o <= 1'b0;
         endcase
      end
   end

   // Q data only, qualified by pair_valid_o
   always_ff @(posedge dsp_clk)
   begin
      if (cap_phase == IQ_PHASE_Q)
      begin
         pair_q_o <= rx_d_i;
      end
   end

endmodule

//--- source/lms_pkg.sv
package lms_pkg;

   // One I or Q word on the LMS sample bus
   parameter int SAMPLE_W = 12;

   // Transceiver channels on the board
   parameter int NUM_CH = 2;

   parameter int FIFO_DEPTH_DEF = 8;  // Pairs per channel, power of two

   // Raw unsigned converter code
   typedef logic [SAMPLE_W-1:0] sample_t;

   // Level of the IQ select line
   // Low carries I, high carries Q on both RX and TX buses
   typedef enum logic
   {
      IQ_PHASE_I = 1'b0,
      IQ_PHASE_Q = 1'b1
   } iq_phase_e;

endpackage
